//--- all.f
design/cmprs_buf_pkg.sv
design/tile_buffer.sv
design/block_dc_accum.sv
design/block_reader.sv
design/dc_subtract.sv
design/cmprs_buf_average.sv
test/cmprs_buf_asserts.sv
test/tb_cmprs_buf.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator and run it, exit status is the result
verilator --binary --timing --assert --top-module tb_cmprs_buf -f all.f -o tb_sim \
    && ./obj_dir/tb_sim \
    || { echo "build or simulation failed"; exit 1; }

//--- test/tb_cmprs_buf.sv
// testbench for the macroblock buffer with block average removal
// clock, reset and random macroblock writes from a fixed seed
// reference model of block averages and the expected output queue
// output monitor, compare task and cycle limit
`timescale 1ns/1ps

module tb_cmprs_buf;

    localparam int num_mb         = 8;
    localparam int timeout_cycles = num_mb * 1200;  // ~620 write cycles per mb plus drain

    logic                                   xclk = 1'b0;  // no edge at time 0
    logic                                   arst_n;
    logic                                   mb_start;
    cmprs_buf_pkg::cmprs_mode_e             mode;
    logic                                   subtract_dc;
    logic                                   y_we;
    logic [cmprs_buf_pkg::block_addr_w+1:0] y_addr;
    logic [cmprs_buf_pkg::sample_w-1:0]     y_data;
    logic                                   c_we;
    logic [cmprs_buf_pkg::block_addr_w:0]   c_addr;
    logic [cmprs_buf_pkg::sample_w-1:0]     c_data;
    logic [cmprs_buf_pkg::out_w-1:0]        data_out;
    logic [cmprs_buf_pkg::sample_w-1:0]     avr_out;
    logic                                   dv;
    logic                                   ds;
    logic [cmprs_buf_pkg::tile_w-1:0]       tn;

    integer      seed = 32'h8723_0fec;
    logic [23:0] exp_q [$];                 // {last, ds, tn, avr, data}
    int          mb_out = 0;                // macroblocks fully read out
    int          cycles;
    string       mb_name [num_mb];

    cmprs_buf_average i_cmprs_buf_average (
        .xclk (xclk), .arst_n (arst_n), .mb_start (mb_start), .mode (mode),
        .subtract_dc (subtract_dc), .y_we (y_we), .y_addr (y_addr), .y_data (y_data),
        .c_we (c_we), .c_addr (c_addr), .c_data (c_data), .data_out (data_out),
        .avr_out (avr_out), .dv (dv), .ds (ds), .tn (tn)
    );

    bind cmprs_buf_average cmprs_buf_asserts i_cmprs_buf_asserts (
        .xclk (xclk), .arst_n (arst_n), .mb_start (mb_start), .dv (dv), .ds (ds), .tn (tn)
    );

    initial begin : clock_gen
        forever #2 xclk = ~xclk;            // 4 ns period
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            abort_run($sformatf("** Error %s %s: expected %0h, actual %0h",
                                mb_name[mb_out], what, exp, act));
        end
    endtask

    task automatic write_sample(input int t, input int pos, input int v);
        if (t < cmprs_buf_pkg::y_blocks) begin
            y_we   = 1'b1;
            y_addr = {2'(t), 6'(pos)};      // block index on top
            y_data = 9'(v);
        end else begin
            c_we   = 1'b1;
            c_addr = {t[0], 6'(pos)};       // tile 4 is Cb, tile 5 is Cr
            c_data = 9'(v);
        end
        @(negedge xclk);
        y_we = 1'b0;
        c_we = 1'b0;
    endtask

    task automatic write_macroblock(input int k);
        cmprs_buf_pkg::cmprs_mode_e m;
        logic sub;
        int   nb;
        int   smp [6][64];
        int   avg [6];
        int   sum;
        int   step;
        int   off;
        int   bias;
        int   spread;
        int   pos;
        m   = (($random(seed) & 1) != 0) ? cmprs_buf_pkg::mode_mono : cmprs_buf_pkg::mode_color;
        sub = ($random(seed) & 3) != 0;     // mostly on
        if (k == 0) begin
            m   = cmprs_buf_pkg::mode_color;
            sub = 1'b1;
        end
        if (k == 1) m = cmprs_buf_pkg::mode_mono;
        if (k == 2) sub = 1'b0;
        nb = (m == cmprs_buf_pkg::mode_mono) ? 4 : 6;
        mb_name[k] = $sformatf("mb%0d %s sub%0d", k, (nb == 4) ? "mono" : "colour", sub);
        while (mb_out < k - 1) @(negedge xclk);  // page of mb k-2 must be read out
        mb_start    = 1'b1;
        mode        = m;
        subtract_dc = sub;
        @(negedge xclk);
        mb_start = 1'b0;
        for (int t = 0; t < nb; t++) begin
            spread = 1 + ($random(seed) & 3);
            bias   = $random(seed) % 128;   // block dc offset
            step   = ($random(seed) & 62) | 1;  // odd step, so a permutation of 0..63
            off    = $random(seed) & 63;
            sum    = 0;
            for (int i = 0; i < 64; i++) begin
                pos = (off + i * step) & 63;
                smp[t][pos] = bias + ($random(seed) >>> (23 + spread));
                sum += smp[t][pos];
                if (($random(seed) & 3) == 0) repeat (1 + ($random(seed) & 3)) @(negedge xclk);
                write_sample(t, pos, smp[t][pos]);
            end
            avg[t] = sub ? (sum >>> 6) : 0; // floor(sum/64)
        end
        for (int t = 0; t < nb; t++) begin
            for (int p = 0; p < 64; p++) begin
                exp_q.push_back({1'(t == nb - 1 && p == 63), 1'(p == 0), 3'(t),
                                 9'(avg[t]), 10'(smp[t][p] - avg[t])});
            end
        end
    endtask

    initial begin : monitor
        logic [23:0] e;
        logic        in_run;
        in_run = 1'b0;
        forever begin
            @(negedge xclk);                // outputs settle after posedge
            if (!dv) begin
                if (ds) abort_run("ds high while dv is low");
                if (in_run) abort_run("dv dropped inside a macroblock readout");
            end else if (exp_q.size() == 0) begin
                abort_run("dv high with no macroblock waiting for readout");
            end else begin
                e = exp_q.pop_front();
                check("data_out", 32'(e[9:0]), 32'(data_out));
                check("avr_out", 32'(e[18:10]), 32'(avr_out));
                check("tn", 32'(e[21:19]), 32'(tn));
                check("ds", 32'(e[22]), 32'(ds));
                in_run = !e[23];
                if (e[23]) mb_out++;
            end
        end
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < timeout_cycles) begin
            @(posedge xclk);
            cycles++;
        end
        abort_run("timeout, readout did not finish within the cycle limit");
    end

    initial begin : stimulus
        arst_n      = 1'b0;
        mb_start    = 1'b0;
        mode        = cmprs_buf_pkg::mode_color;
        subtract_dc = 1'b0;
        y_we        = 1'b0;
        y_addr      = '0;
        y_data      = '0;
        c_we        = 1'b0;
        c_addr      = '0;
        c_data      = '0;
        repeat (3) @(negedge xclk);         // 3 cycles in reset
        arst_n = 1'b1;
        repeat (2) @(negedge xclk);
        for (int k = 0; k < num_mb; k++) write_macroblock(k);
        while (mb_out < num_mb) @(negedge xclk);
        repeat (8) @(negedge xclk);         // room for a stray dv
        if (dv) begin
            abort_run("unexpected output after the last macroblock");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

//--- test/cmprs_buf_asserts.sv
// concurrent checks on the buffer top level outputs
// count of started macroblocks whose readout has not begun
// ds/dv relation, stable tile number, no third page, dv low in reset
`timescale 1ns/1ps

module cmprs_buf_asserts (
    input logic                             xclk,
    input logic                             arst_n,
    input logic                             mb_start,
    input logic                             dv,
    input logic                             ds,
    input logic [cmprs_buf_pkg::tile_w-1:0] tn
);

    logic [1:0] pending;                    // mb started, first ds not yet seen

    always_ff @(posedge xclk or negedge arst_n) begin
        if (!arst_n) begin
            pending <= '0;
        end else begin
            pending <= pending + 2'(mb_start) - 2'(ds && tn == '0);
        end
    end

    assert property (@(posedge xclk) disable iff (!arst_n) ds |-> dv)
        else $error("ds without dv");
    assert property (@(posedge xclk) disable iff (!arst_n) (dv && !ds) |-> tn == $past(tn))
        else $error("tile number changed inside a block");
    assert property (@(posedge xclk) disable iff (!arst_n) mb_start |-> pending < 2'd2)
        else $error("mb_start while two pages are pending");
    assert property (@(posedge xclk) !arst_n |=> !dv)
        else $error("dv high in reset");

endmodule

//--- design/cmprs_buf_average.sv
// top level of the macroblock buffer with block average removal
// luma and chroma sample buffers
// block average accumulation, readout sequencing, average subtraction
`timescale 1ns/1ps

module cmprs_buf_average (
    input  logic                                  xclk,
    input  logic                                  arst_n,
    input  logic                                  mb_start,
    input  cmprs_buf_pkg::cmprs_mode_e            mode,
    input  logic                                  subtract_dc,
    input  logic                                  y_we,
    input  logic [cmprs_buf_pkg::block_addr_w+1:0] y_addr,
    input  logic [cmprs_buf_pkg::sample_w-1:0]     y_data,
    input  logic                                  c_we,
    input  logic [cmprs_buf_pkg::block_addr_w:0]   c_addr,
    input  logic [cmprs_buf_pkg::sample_w-1:0]     c_data,
    output logic [cmprs_buf_pkg::out_w-1:0]        data_out,
    output logic [cmprs_buf_pkg::sample_w-1:0]     avr_out,
    output logic                                  dv,
    output logic                                  ds,
    output logic [cmprs_buf_pkg::tile_w-1:0]       tn
);

    logic                                  wpage;     // page being written
    logic                                  rpage;     // page being read
    logic                                  dc_we;
    logic [cmprs_buf_pkg::dc_addr_w-1:0]    dc_waddr;
    logic [cmprs_buf_pkg::sample_w-1:0]     dc_wdata;
    logic [cmprs_buf_pkg::dc_addr_w-1:0]    dc_raddr;
    logic [5:0]                            block_done;
    logic                                  y_re;
    logic                                  c_re;
    logic [cmprs_buf_pkg::block_addr_w+1:0] raddr;
    logic [cmprs_buf_pkg::sample_w-1:0]     y_rdata;
    logic [cmprs_buf_pkg::sample_w-1:0]     c_rdata;

    tile_buffer #(.NUM_BLOCKS(cmprs_buf_pkg::y_blocks)) i_y_buffer (
        .xclk  (xclk),    .wpage (wpage),    .we    (y_we),
        .waddr (y_addr),  .wdata (y_data),   .rpage (rpage),
        .re    (y_re),    .raddr (raddr),    .rdata (y_rdata)
    );

    tile_buffer #(.NUM_BLOCKS(cmprs_buf_pkg::c_blocks)) i_c_buffer (
        .xclk  (xclk),    .wpage (wpage),    .we    (c_we),
        .waddr (c_addr),  .wdata (c_data),   .rpage (rpage),
        .re    (c_re),    .raddr (raddr[cmprs_buf_pkg::block_addr_w:0]),
        .rdata (c_rdata)
    );

    block_dc_accum i_block_dc_accum (
        .xclk        (xclk),        .arst_n     (arst_n),     .mb_start (mb_start),
        .subtract_dc (subtract_dc), .y_we       (y_we),       .y_addr   (y_addr),
        .y_data      (y_data),      .c_we       (c_we),       .c_addr   (c_addr),
        .c_data      (c_data),      .wpage      (wpage),      .dc_we    (dc_we),
        .dc_waddr    (dc_waddr),    .dc_wdata   (dc_wdata),   .block_done (block_done)
    );

    block_reader i_block_reader (
        .xclk       (xclk),       .arst_n   (arst_n),    .mb_start (mb_start),
        .mode       (mode),       .wpage    (wpage),     .block_done (block_done),
        .rpage      (rpage),      .y_re     (y_re),      .c_re     (c_re),
        .raddr      (raddr),      .dc_raddr (dc_raddr),  .dv       (dv),
        .ds         (ds),         .tn       (tn)
    );

    dc_subtract i_dc_subtract (
        .xclk      (xclk),      .arst_n   (arst_n),    .dc_we    (dc_we),
        .dc_waddr  (dc_waddr),  .dc_wdata (dc_wdata),  .dc_raddr (dc_raddr),
        .tile_is_c (c_re),      .y_rdata  (y_rdata),   .c_rdata  (c_rdata),
        .data_out  (data_out),  .avr_out  (avr_out)
    );

endmodule

//--- design/dc_subtract.sv
// 16 entry table of block averages, two pages of six tiles
// registered table read, parallel to the buffer read
// luma or chroma select and registered average subtraction
`timescale 1ns/1ps

module dc_subtract (
    input  logic                                xclk,
    input  logic                                arst_n,
    input  logic                                dc_we,
    input  logic [cmprs_buf_pkg::dc_addr_w-1:0]  dc_waddr,
    input  logic [cmprs_buf_pkg::sample_w-1:0]   dc_wdata,
    input  logic [cmprs_buf_pkg::dc_addr_w-1:0]  dc_raddr,  // with the buffer address
    input  logic                                tile_is_c, // with the buffer address
    input  logic [cmprs_buf_pkg::sample_w-1:0]   y_rdata,
    input  logic [cmprs_buf_pkg::sample_w-1:0]   c_rdata,
    output logic [cmprs_buf_pkg::out_w-1:0]      data_out,  // 2 cycles after address
    output logic [cmprs_buf_pkg::sample_w-1:0]   avr_out
);

    localparam int sw = cmprs_buf_pkg::sample_w;
    localparam int ow = cmprs_buf_pkg::out_w;

    logic [sw-1:0] avr_tab [2 ** cmprs_buf_pkg::dc_addr_w];
    logic [sw-1:0] avr_r;                  // aligned with buffer rdata
    logic [sw-1:0] avr_d;                  // aligned with data_out
    logic          is_c_d;
    logic [sw-1:0] smp;
    logic [ow-1:0] diff;

    always_ff @(posedge xclk) begin
        if (dc_we) begin
            avr_tab[dc_waddr] <= dc_wdata;
        end
        avr_r    <= avr_tab[dc_raddr];
        avr_d    <= avr_r;
        data_out <= diff;
    end

    always_ff @(posedge xclk or negedge arst_n) begin
        if (!arst_n) begin
            is_c_d <= 1'b0;
        end else begin
            is_c_d <= tile_is_c;           // buffer select one cycle late
        end
    end

    assign smp     = is_c_d ? c_rdata : y_rdata;
    assign diff    = ow'($signed(smp)) - ow'($signed(avr_r));  // cannot overflow 10 bits
    assign avr_out = avr_d;

endmodule

//--- design/block_reader.sv
// per page mode latch and block done bookkeeping
// readout start when every block the mode needs is averaged
// read address, page and buffer select sequencing
// valid, strobe and tile number delayed to the output data
`timescale 1ns/1ps

module block_reader (
    input  logic                                  xclk,
    input  logic                                  arst_n,
    input  logic                                  mb_start,
    input  cmprs_buf_pkg::cmprs_mode_e            mode,       // sampled at mb_start
    input  logic                                  wpage,
    input  logic [5:0]                            block_done,
    output logic                                  rpage,
    output logic                                  y_re,
    output logic                                  c_re,
    output logic [cmprs_buf_pkg::block_addr_w+1:0] raddr,
    output logic [cmprs_buf_pkg::dc_addr_w-1:0]    dc_raddr,
    output logic                                  dv,
    output logic                                  ds,
    output logic [cmprs_buf_pkg::tile_w-1:0]       tn
);

    localparam int nb  = cmprs_buf_pkg::y_blocks + cmprs_buf_pkg::c_blocks;
    localparam int baw = cmprs_buf_pkg::block_addr_w;
    localparam int tw  = cmprs_buf_pkg::tile_w;
    localparam int cw  = tw + baw;
    localparam logic [nb-1:0] y_mask = nb'((1 << cmprs_buf_pkg::y_blocks) - 1);

    cmprs_buf_pkg::cmprs_mode_e mode_pg [2];  // mode of each page
    cmprs_buf_pkg::cmprs_mode_e rd_mode;      // mode of the page being read
    logic [nb-1:0] done_pg [2];               // averaged blocks per page
    logic [nb-1:0] need [2];
    logic [1:0]    pend;                      // filled or filling, not yet read
    logic [1:0]    complete;
    logic [nb-1:0] to_old;                    // done bit belongs to older page
    logic          old_pg;
    logic          start_go;
    logic          start_pg;
    logic          start_read;                // first address cycle
    logic          reading;
    logic          rd_on;
    logic          rd_last;
    logic [cw-1:0] rd_cnt;                    // {tile, address in block}
    logic [1:0]    dv_d;
    logic [1:0]    ds_d;
    logic [tw-1:0] tn_d [2];

    always_comb begin
        old_pg = ~wpage;
        for (int p = 0; p < 2; p++) begin
            need[p]     = (mode_pg[p] == cmprs_buf_pkg::mode_mono) ? y_mask : '1;
            complete[p] = pend[p] && ((done_pg[p] & need[p]) == need[p]);
        end
        // late done of the previous mb after mb_start already flipped wpage
        to_old   = {nb{pend[old_pg]}} & need[old_pg] & ~done_pg[old_pg];
        rd_on    = start_read | reading;
        start_go = (|complete) && !rd_on;
        start_pg = !complete[0];
        rd_last  = (rd_mode == cmprs_buf_pkg::mode_mono) ?
                   (rd_cnt == cw'(cmprs_buf_pkg::y_blocks * cmprs_buf_pkg::block_samples - 1)) :
                   (rd_cnt == cw'(nb * cmprs_buf_pkg::block_samples - 1));
    end

    always_ff @(posedge xclk or negedge arst_n) begin
        if (!arst_n) begin
            pend       <= '0;
            done_pg[0] <= '0;
            done_pg[1] <= '0;
            mode_pg[0] <= cmprs_buf_pkg::mode_color;
            mode_pg[1] <= cmprs_buf_pkg::mode_color;
            rd_mode    <= cmprs_buf_pkg::mode_color;
            start_read <= 1'b0;
            reading    <= 1'b0;
            rpage      <= 1'b0;
            rd_cnt     <= '0;
            dv_d       <= '0;
            ds_d       <= '0;
        end else begin
            done_pg[old_pg] <= done_pg[old_pg] | (block_done & to_old);
            done_pg[wpage]  <= done_pg[wpage] | (block_done & ~to_old);
            start_read      <= start_go;
            reading         <= rd_on && !rd_last;
            if (start_go) begin
                done_pg[start_pg] <= '0;          // set consumed by this readout
                pend[start_pg]    <= 1'b0;
                rpage             <= start_pg;
                rd_mode           <= mode_pg[start_pg];
                rd_cnt            <= '0;
            end else if (rd_on) begin
                rd_cnt <= rd_cnt + 1'b1;
            end
            if (mb_start) begin                   // new mb goes to the other page
                mode_pg[old_pg] <= mode;
                pend[old_pg]    <= 1'b1;
                done_pg[old_pg] <= '0;
            end
            dv_d <= {dv_d[0], rd_on};
            ds_d <= {ds_d[0], rd_on && (rd_cnt[baw-1:0] == '0)};
        end
    end

    always_ff @(posedge xclk) begin
        tn_d[0] <= rd_cnt[baw +: tw];            // tile follows the data pipe
        tn_d[1] <= tn_d[0];
    end

    assign y_re     = rd_on && !rd_cnt[cw-1];    // tiles 0..3
    assign c_re     = rd_on && rd_cnt[cw-1];     // tiles 4, 5
    assign raddr    = rd_cnt[baw+1:0];           // chroma buffer takes the low 7 bits
    assign dc_raddr = {rpage, rd_cnt[baw +: tw]};
    assign dv       = dv_d[1];
    assign ds       = ds_d[1];
    assign tn       = tn_d[1];

endmodule

//--- design/block_dc_accum.sv
// per block sample sums and sample counters
// write page and per page subtract enable, toggled by mb_start
// truncated block averages written to the average table
// one block done pulse per table write
`timescale 1ns/1ps

module block_dc_accum (
    input  logic                                  xclk,
    input  logic                                  arst_n,
    input  logic                                  mb_start,    // before first write of a mb
    input  logic                                  subtract_dc, // sampled at mb_start
    input  logic                                  y_we,
    input  logic [cmprs_buf_pkg::block_addr_w+1:0] y_addr,
    input  logic [cmprs_buf_pkg::sample_w-1:0]     y_data,
    input  logic                                  c_we,
    input  logic [cmprs_buf_pkg::block_addr_w:0]   c_addr,      // msb selects Cb/Cr
    input  logic [cmprs_buf_pkg::sample_w-1:0]     c_data,
    output logic                                  wpage,
    output logic                                  dc_we,
    output logic [cmprs_buf_pkg::dc_addr_w-1:0]    dc_waddr,
    output logic [cmprs_buf_pkg::sample_w-1:0]     dc_wdata,
    output logic [5:0]                            block_done
);

    localparam int nb  = cmprs_buf_pkg::y_blocks + cmprs_buf_pkg::c_blocks;
    localparam int sw  = cmprs_buf_pkg::sample_w;
    localparam int uw  = cmprs_buf_pkg::sum_w;
    localparam int baw = cmprs_buf_pkg::block_addr_w;
    localparam int tw  = cmprs_buf_pkg::tile_w;

    logic [1:0]    sub_pg;               // subtract enable per page
    logic [sw-1:0] smp_y;                // registered luma sample
    logic [sw-1:0] smp_c;                // registered chroma sample
    logic [nb-1:0] acc_en;               // one hot, block receiving smp_*
    logic          page_s1;              // page of the registered sample
    logic [uw-1:0] sum [nb];
    logic [baw-1:0] cnt [nb];            // wraps to 0 after 64 samples
    logic [nb-1:0] fin;                  // 64th sample being summed
    logic [nb-1:0] pend;                 // finished, table write still owed
    logic [nb-1:0] pend_pg;              // page of each owed write
    logic [nb-1:0] req;
    logic [nb-1:0] req_pg;
    logic [nb-1:0] grant;
    logic [tw-1:0] grant_idx;
    logic [tw-1:0] dc_idx;               // tile of the current table write
    logic          dc_page;

    always_comb begin
        for (int i = 0; i < nb; i++) begin
            fin[i] = acc_en[i] && (cnt[i] == '1);
        end
        req = pend | fin;                 // Y and C may finish in one cycle
        grant_idx = '0;
        for (int i = nb - 1; i >= 0; i--) begin
            if (req[i]) grant_idx = tw'(i);   // lowest tile first
        end
        grant = req[grant_idx] ? (nb'(1) << grant_idx) : '0;
        for (int i = 0; i < nb; i++) begin
            req_pg[i] = fin[i] ? page_s1 : pend_pg[i];
        end
    end

    always_ff @(posedge xclk) begin
        smp_y <= y_data;                  // only used when acc_en says so
        smp_c <= c_data;
        for (int i = 0; i < nb; i++) begin
            if (acc_en[i]) begin          // first sample restarts the sum
                sum[i] <= ((cnt[i] == '0) ? '0 : sum[i]) +
                          uw'($signed((i < cmprs_buf_pkg::y_blocks) ? smp_y : smp_c));
            end
        end
    end

    always_ff @(posedge xclk or negedge arst_n) begin
        if (!arst_n) begin
            wpage      <= 1'b0;
            sub_pg     <= '0;
            acc_en     <= '0;
            page_s1    <= 1'b0;
            pend       <= '0;
            pend_pg    <= '0;
            dc_we      <= 1'b0;
            dc_idx     <= '0;
            dc_page    <= 1'b0;
            block_done <= '0;
            for (int i = 0; i < nb; i++) cnt[i] <= '0;
        end else begin
            if (mb_start) begin
                wpage          <= ~wpage;
                sub_pg[~wpage] <= subtract_dc;    // for the page about to fill
            end
            for (int i = 0; i < cmprs_buf_pkg::y_blocks; i++) begin
                acc_en[i] <= y_we && (y_addr[baw +: 2] == 2'(i));
            end
            for (int i = 0; i < cmprs_buf_pkg::c_blocks; i++) begin
                acc_en[cmprs_buf_pkg::y_blocks + i] <= c_we && (c_addr[baw] == 1'(i));
            end
            page_s1 <= wpage;
            for (int i = 0; i < nb; i++) begin
                if (acc_en[i]) cnt[i] <= cnt[i] + 1'b1;
            end
            pend       <= req & ~grant;
            pend_pg    <= req_pg;
            dc_we      <= |req;
            dc_idx     <= grant_idx;
            dc_page    <= req_pg[grant_idx];
            block_done <= grant;              // done goes with the table write
        end
    end

    assign dc_waddr = {dc_page, dc_idx};
    // sum is floor(sum/64) in its top bits
    assign dc_wdata = sub_pg[dc_page] ? sum[dc_idx][uw-1 -: sw] : '0;

endmodule

//--- design/tile_buffer.sv
// two page sample buffer for the blocks of one macroblock
// write port addressed by page and in-macroblock address
// registered read port, sequenced by the block reader
`timescale 1ns/1ps

module tile_buffer #(
    parameter int NUM_BLOCKS = 4,                 // blocks per page
    localparam int AW = $clog2(NUM_BLOCKS) + cmprs_buf_pkg::block_addr_w
) (
    input  logic                              xclk,
    // write side
    input  logic                              wpage,  // page being filled
    input  logic                              we,
    input  logic [AW-1:0]                     waddr,  // block index on top
    input  logic [cmprs_buf_pkg::sample_w-1:0] wdata,
    // read side
    input  logic                              rpage,  // page being sent out
    input  logic                              re,
    input  logic [AW-1:0]                     raddr,
    output logic [cmprs_buf_pkg::sample_w-1:0] rdata   // one cycle after raddr
);

    localparam int DEPTH = 2 * NUM_BLOCKS * cmprs_buf_pkg::block_samples;

    logic [cmprs_buf_pkg::sample_w-1:0] mem [DEPTH]; // both pages

    always_ff @(posedge xclk) begin
        if (we) begin
            mem[{wpage, waddr}] <= wdata;         // any order within a block
        end
    end

    always_ff @(posedge xclk) begin
        if (re) begin
            rdata <= mem[{rpage, raddr}];         // holds last word when idle
        end
    end

endmodule

//--- design/cmprs_buf_pkg.sv
// shared widths and block geometry of the macroblock buffer
// sample, output and accumulator widths
// blocks per macroblock, tile numbering, average table address
// compression mode enum
package cmprs_buf_pkg;

    // sample widths
    localparam int sample_w      = 9;   // signed input sample
    localparam int out_w         = 10;  // signed sample minus average
    localparam int sum_w         = 15;  // 64 x 9 bit signed, no overflow

    // block geometry
    localparam int block_samples = 64;  // 8x8
    localparam int block_addr_w  = 6;   // address inside one block

    // macroblock layout
    localparam int y_blocks      = 4;   // tiles 0..3
    localparam int c_blocks      = 2;   // tile 4 is Cb, tile 5 is Cr
    localparam int tile_w        = 3;   // tile number 0..5

    // average table, page bit on top of the tile number
    localparam int dc_addr_w     = 4;

    // macroblock layout mode, sampled at mb_start
    typedef enum logic {
        mode_color = 1'b0,              // 4:2:0, six blocks
        mode_mono  = 1'b1               // luma only, four blocks
    } cmprs_mode_e;

endpackage
